// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = coreTb
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = >>> PASS
FAIL_MSG   = >>> FAIL

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: logic/codeMemory.sv
/*
  Program storage, one instruction per word, written by load strobes.
  The read register follows readAddr every cycle; the pointer holds still
  from fetch through execute, so the word seen in execute is the fetched one.
*/
`timescale 1ns/1ps
`default_nettype none

module codeMemory (
  input  logic                clock,
  input  cpuPkg::codeLoadT    codeLoad,
  input  cpuPkg::codeAddrT    readAddr,
  output cpuPkg::instructionT instruction
);

  cpuPkg::instructionT words [cpuPkg::CodeWords];

  always_ff @(posedge clock) begin
    if (codeLoad.valid) begin
      words[codeLoad.address] <= codeLoad.instruction;  // load port
    end
    instruction <= words[readAddr];                     // registered read
  end

  loadInRange: assert property (@(posedge clock)
    codeLoad.valid |-> int'(codeLoad.address) < cpuPkg::CodeWords)
    else $error("code load beyond code memory");

endmodule

`default_nettype wire

// File: logic/coreTop.sv
/*
  Top level of the test processor. Code loads are ignored while a program runs.
  Strobes have no back-pressure; outValid/outData must be taken when strobed.
*/
`timescale 1ns/1ps
`default_nettype none

module coreTop (
  input  logic             clock,
  input  logic             arstN,
  input  cpuPkg::codeLoadT codeLoad,
  input  logic             start,
  input  cpuPkg::codeAddrT programLength,
  input  logic             inPush,
  input  cpuPkg::wordT     inData,
  output logic             outValid,
  output cpuPkg::wordT     outData,
  output logic             finished
);

  logic                executeStrobe;
  logic                clearStrobe;
  logic                loadAllowed;
  logic                inRange;
  logic                needInput;
  logic                writeEnable;
  logic                takeBranch;
  logic                popStrobe;
  cpuPkg::codeAddrT    codeAddr;
  cpuPkg::codeLoadT    gatedLoad;
  cpuPkg::instructionT instruction;
  cpuPkg::wordT        source1Value;
  cpuPkg::wordT        source2Value;
  cpuPkg::wordT        result;
  cpuPkg::wordT        offset;
  cpuPkg::wordT        head;
  cpuPkg::inCountT     inCount;

  always_comb begin
    gatedLoad       = codeLoad;
    gatedLoad.valid = codeLoad.valid && loadAllowed;  // no loads mid-run
  end

  sequencer sequencer0 (
    .clock, .arstN, .start, .inRange, .needInput,
    .fetchStrobe (),
    .executeStrobe, .clearStrobe, .finished, .loadAllowed
  );

  instructionPointer instructionPointer0 (
    .clock, .arstN,
    .clear      (clearStrobe),
    .advance    (executeStrobe),
    .takeBranch, .offset, .programLength,
    .ip         (codeAddr),
    .inRange
  );

  codeMemory codeMemory0 (
    .clock,
    .codeLoad   (gatedLoad),
    .readAddr   (codeAddr),
    .instruction
  );

  localStore localStore0 (
    .clock, .arstN,
    .clear      (clearStrobe),
    .instruction, .writeEnable, .result, .source1Value, .source2Value
  );

  executeUnit executeUnit0 (
    .clock, .arstN, .executeStrobe, .instruction, .source1Value, .source2Value,
    .inData     (head),
    .inCount, .result, .writeEnable, .takeBranch, .popStrobe, .needInput,
    .offset, .outValid, .outData
  );

  inChannel inChannel0 (
    .clock, .arstN,
    .clear      (clearStrobe),
    .inPush, .inData, .popStrobe, .head, .inCount
  );

endmodule

`default_nettype wire

// File: logic/cpuPkg.sv
/*
  Shared sizes, encodings and types of the test processor.
  Opcodes outside opcodeT run as nop; mode 2'b11 reads as immediate and is never written.
*/
`default_nettype none

package cpuPkg;

  // --------------------
  // sizes
  localparam int WordWidth    = 12;
  localparam int AddressWidth = 10;  // operand address field
  localparam int LocalWords   = 32;
  localparam int CodeWords    = 64;
  localparam int InDepth      = 8;   // power of two, ring pointers wrap

  typedef logic signed [WordWidth-1:0]    wordT;
  typedef logic [$clog2(LocalWords)-1:0]  localAddrT;
  typedef logic [$clog2(CodeWords)-1:0]   codeAddrT;
  typedef logic [$clog2(InDepth):0]       inCountT;  // 0 to InDepth

  // --------------------
  // instruction encoding
  typedef enum logic [7:0] {
    opAdd      = 8'd0,
    opSubtract = 8'd1,
    opMov      = 8'd2,
    opNot      = 8'd3,
    opJmp      = 8'd4,
    opJEq      = 8'd5,
    opJLt      = 8'd6,
    opJFalse   = 8'd7,
    opIn       = 8'd8,
    opInSize   = 8'd9,
    opOut      = 8'd10,
    opNop      = 8'd11
  } opcodeT;

  typedef enum logic [1:0] {
    modeImmediate = 2'd0,  // address field itself
    modeDirect    = 2'd1,  // local[delta + address]
    modeIndirect  = 2'd2   // local[delta + local[address]]
  } modeT;

  typedef struct packed {
    modeT                    mode;
    logic [3:0]              delta;
    logic [AddressWidth-1:0] address;
  } operandT;

  typedef struct packed {
    opcodeT  opcode;
    operandT target;   // also the jump offset
    operandT source1;
    operandT source2;
  } instructionT;

  typedef struct packed {
    logic        valid;
    codeAddrT    address;
    instructionT instruction;
  } codeLoadT;

  typedef enum logic [2:0] {
    seqIdle,
    seqFetch,
    seqExecute,
    seqWaitIn,
    seqDone
  } seqStateT;

  // address field as a signed word
  function automatic wordT immediateValue(operandT op);
    return {{(WordWidth-AddressWidth){op.address[AddressWidth-1]}}, op.address};
  endfunction

endpackage

`default_nettype wire

// File: logic/executeUnit.sv
/*
  Decodes the current instruction and produces the result, branch and channel controls.
  All controls are qualified by executeStrobe except needInput, which the
  sequencer only looks at in execute and wait states.
*/
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
  input  logic                clock,
  input  logic                arstN,
  input  logic                executeStrobe,
  input  cpuPkg::instructionT instruction,
  input  cpuPkg::wordT        source1Value,
  input  cpuPkg::wordT        source2Value,
  input  cpuPkg::wordT        inData,
  input  cpuPkg::inCountT     inCount,
  output cpuPkg::wordT        result,
  output logic                writeEnable,
  output logic                takeBranch,
  output logic                popStrobe,
  output logic                needInput,
  output cpuPkg::wordT        offset,
  output logic                outValid,
  output cpuPkg::wordT        outData
);

  logic writes;       // opcode stores a result
  logic branchTaken;
  logic isIn;
  logic isOut;
  logic inEmpty;

  assign isIn    = instruction.opcode == cpuPkg::opIn;
  assign isOut   = instruction.opcode == cpuPkg::opOut;
  assign inEmpty = inCount == '0;
  assign offset  = cpuPkg::immediateValue(instruction.target);

  // --------------------
  // decode
  always_comb begin
    result      = '0;
    writes      = 1'b0;
    branchTaken = 1'b0;
    case (instruction.opcode)
      cpuPkg::opAdd: begin
        result = source1Value + source2Value;
        writes = 1'b1;
      end
      cpuPkg::opSubtract: begin
        result = source1Value - source2Value;
        writes = 1'b1;
      end
      cpuPkg::opMov: begin
        result = source1Value;
        writes = 1'b1;
      end
      cpuPkg::opNot: begin
        result = cpuPkg::wordT'(source1Value == '0);  // 1 for zero
        writes = 1'b1;
      end
      cpuPkg::opJmp:    branchTaken = 1'b1;
      cpuPkg::opJEq:    branchTaken = source1Value == source2Value;
      cpuPkg::opJLt:    branchTaken = source1Value < source2Value;  // signed
      cpuPkg::opJFalse: branchTaken = source1Value == '0;
      cpuPkg::opIn: begin
        result = inData;      // channel head
        writes = !inEmpty;
      end
      cpuPkg::opInSize: begin
        result = cpuPkg::wordT'(inCount);
        writes = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign needInput   = isIn && inEmpty;
  assign writeEnable = executeStrobe && writes;
  assign takeBranch  = executeStrobe && branchTaken;
  assign popStrobe   = executeStrobe && isIn && !inEmpty;

  // --------------------
  // output channel
  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= executeStrobe && isOut;
    end
  end

  always_ff @(posedge clock) begin
    if (executeStrobe && isOut) begin
      outData <= source1Value;
    end
  end

  // a fetch always separates two executes
  outSingleCycle: assert property (@(posedge clock) disable iff (!arstN)
    outValid |=> !outValid)
    else $error("outValid held for two cycles");

endmodule

`default_nettype wire

// File: logic/inChannel.sv
/*
  Input ring buffer of InDepth words with a count.
  A push to a full buffer is dropped. A push in the clear cycle lands in the emptied buffer.
*/
`timescale 1ns/1ps
`default_nettype none

module inChannel (
  input  logic            clock,
  input  logic            arstN,
  input  logic            clear,
  input  logic            inPush,
  input  cpuPkg::wordT    inData,
  input  logic            popStrobe,
  output cpuPkg::wordT    head,
  output cpuPkg::inCountT inCount
);

  typedef logic [$clog2(cpuPkg::InDepth)-1:0] slotT;

  cpuPkg::wordT slots [cpuPkg::InDepth];
  slotT         readPtr;
  slotT         writePtr;
  slotT         pushSlot;
  logic         hasRoom;
  logic         accept;
  logic         take;

  assign hasRoom  = inCount < cpuPkg::inCountT'(cpuPkg::InDepth);
  assign accept   = inPush && (clear || hasRoom);
  assign take     = popStrobe && !clear && (inCount != '0);
  assign pushSlot = clear ? '0 : writePtr;
  assign head     = slots[readPtr];

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      readPtr  <= '0;
      writePtr <= '0;
      inCount  <= '0;
    end else if (clear) begin
      readPtr  <= '0;
      writePtr <= slotT'(inPush);  // flush, keep a same-cycle push
      inCount  <= cpuPkg::inCountT'(inPush);
    end else begin
      if (accept) begin
        writePtr <= writePtr + 1'b1;
      end
      if (take) begin
        readPtr <= readPtr + 1'b1;
      end
      inCount <= inCount + cpuPkg::inCountT'(accept) - cpuPkg::inCountT'(take);
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      slots[pushSlot] <= inData;
    end
  end

  // --------------------
  // checks
  countBounded: assert property (@(posedge clock) disable iff (!arstN)
    inCount <= cpuPkg::inCountT'(cpuPkg::InDepth))
    else $error("input count above depth");

  noPopEmpty: assert property (@(posedge clock) disable iff (!arstN)
    popStrobe |-> inCount != '0)
    else $error("pop from empty input channel");

  noPushFull: assert property (@(posedge clock) disable iff (!arstN)
    inPush && !clear |-> hasRoom)
    else $error("input push dropped, channel full");

endmodule

`default_nettype wire

// File: logic/instructionPointer.sv
/*
  Instruction pointer with relative jumps.
  The pointer is kept two bits wider than a word so a jump past either end
  of the program is seen as out of range rather than wrapping.
*/
`timescale 1ns/1ps
`default_nettype none

module instructionPointer (
  input  logic             clock,
  input  logic             arstN,
  input  logic             clear,
  input  logic             advance,
  input  logic             takeBranch,
  input  cpuPkg::wordT     offset,
  input  cpuPkg::codeAddrT programLength,
  output cpuPkg::codeAddrT ip,
  output logic             inRange
);

  logic signed [cpuPkg::WordWidth+1:0] pointer;
  logic signed [cpuPkg::WordWidth+1:0] step;
  logic signed [cpuPkg::WordWidth+1:0] lengthWide;
  cpuPkg::codeAddrT                    length;     // latched at start

  assign step = takeBranch ? {{2{offset[cpuPkg::WordWidth-1]}}, offset}
                           : (cpuPkg::WordWidth+2)'(1);
  assign lengthWide = (cpuPkg::WordWidth+2)'(length);

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      pointer <= '0;
      length  <= '0;
    end else if (clear) begin
      pointer <= '0;
      length  <= programLength;
    end else if (advance) begin
      pointer <= pointer + step;  // next or relative jump
    end
  end

  assign ip      = cpuPkg::codeAddrT'(pointer);
  assign inRange = !pointer[cpuPkg::WordWidth+1] && (pointer < lengthWide);

endmodule

`default_nettype wire

// File: logic/localStore.sv
/*
  Local memory with operand resolution for both sources and the target.
  Direct and indirect addresses wrap modulo LocalWords after the delta is added.
  A clear zeroes every word in one cycle, so the store is built from flops.
*/
`timescale 1ns/1ps
`default_nettype none

module localStore (
  input  logic                clock,
  input  logic                arstN,
  input  logic                clear,
  input  cpuPkg::instructionT instruction,
  input  logic                writeEnable,
  input  cpuPkg::wordT        result,
  output cpuPkg::wordT        source1Value,
  output cpuPkg::wordT        source2Value
);

  cpuPkg::wordT      words [cpuPkg::LocalWords];
  cpuPkg::localAddrT targetAddr;
  logic              targetWritable;

  // --------------------
  // operand resolution
  function automatic cpuPkg::localAddrT locate(cpuPkg::operandT op);
    cpuPkg::localAddrT base;
    if (op.mode == cpuPkg::modeIndirect) begin
      base = cpuPkg::localAddrT'(words[cpuPkg::localAddrT'(op.address)]);  // pointer word
    end else begin
      base = cpuPkg::localAddrT'(op.address);
    end
    return base + cpuPkg::localAddrT'(op.delta);  // wraps mod LocalWords
  endfunction

  function automatic cpuPkg::wordT valueOf(cpuPkg::operandT op);
    cpuPkg::wordT value;
    case (op.mode)
      cpuPkg::modeDirect,
      cpuPkg::modeIndirect: value = words[locate(op)];
      default:              value = cpuPkg::immediateValue(op);
    endcase
    return value;
  endfunction

  always_comb begin
    source1Value   = valueOf(instruction.source1);
    source2Value   = valueOf(instruction.source2);
    targetAddr     = locate(instruction.target);
    targetWritable = (instruction.target.mode == cpuPkg::modeDirect) ||
                     (instruction.target.mode == cpuPkg::modeIndirect);
  end

  // --------------------
  // write-back
  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < cpuPkg::LocalWords; i++) begin
        words[i] <= '0;
      end
    end else if (clear) begin
      for (int i = 0; i < cpuPkg::LocalWords; i++) begin
        words[i] <= '0;
      end
    end else if (writeEnable && targetWritable) begin
      words[targetAddr] <= result;  // immediate target drops the result
    end
  end

endmodule

`default_nettype wire

// File: logic/sequencer.sv
/*
  Run control. Start is taken only in idle or done and clears the core.
  Each instruction is one fetch and one execute cycle; an in on an empty
  channel parks in seqWaitIn until a word arrives.
*/
`timescale 1ns/1ps
`default_nettype none

module sequencer (
  input  logic clock,
  input  logic arstN,
  input  logic start,
  input  logic inRange,
  input  logic needInput,
  output logic fetchStrobe,
  output logic executeStrobe,
  output logic clearStrobe,
  output logic finished,
  output logic loadAllowed
);

  cpuPkg::seqStateT state;
  cpuPkg::seqStateT nextState;

  assign loadAllowed   = (state == cpuPkg::seqIdle) || (state == cpuPkg::seqDone);
  assign clearStrobe   = start && loadAllowed;
  assign fetchStrobe   = state == cpuPkg::seqFetch;
  assign executeStrobe = ((state == cpuPkg::seqExecute) || (state == cpuPkg::seqWaitIn)) &&
                         !needInput;
  assign finished      = state == cpuPkg::seqDone;

  always_comb begin
    nextState = state;
    case (state)
      cpuPkg::seqIdle,
      cpuPkg::seqDone: begin
        if (start) begin
          nextState = cpuPkg::seqFetch;
        end
      end
      cpuPkg::seqFetch:   nextState = inRange ? cpuPkg::seqExecute : cpuPkg::seqDone;
      cpuPkg::seqExecute: nextState = needInput ? cpuPkg::seqWaitIn : cpuPkg::seqFetch;
      cpuPkg::seqWaitIn: begin
        if (!needInput) begin
          nextState = cpuPkg::seqFetch;  // word arrived, executed now
        end
      end
      default:            nextState = cpuPkg::seqIdle;
    endcase
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      state <= cpuPkg::seqIdle;
    end else begin
      state <= nextState;
    end
  end

  stateLegal: assert property (@(posedge clock) disable iff (!arstN)
    state inside {cpuPkg::seqIdle, cpuPkg::seqFetch, cpuPkg::seqExecute,
                  cpuPkg::seqWaitIn, cpuPkg::seqDone})
    else $error("sequencer in illegal state");

endmodule

`default_nettype wire

// File: sim/coreModel.svh
/*
  Instruction-level reference model, included inside the testbench module.
  Instruction n of a run reads the input channel in cycle 2n+1 after start;
  an in on an empty channel moves that cycle to the next push.
*/
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// signed reading of a 10-bit address field
function automatic cpuPkg::wordT fieldValue(cpuPkg::operandT op);
  cpuPkg::wordT value;
  value = cpuPkg::wordT'(op.address);  // zero-extended first
  if (op.address[cpuPkg::AddressWidth-1]) begin
    value = value - cpuPkg::wordT'(1 << cpuPkg::AddressWidth);
  end
  return value;
endfunction

function automatic cpuPkg::localAddrT slotOf(cpuPkg::operandT op);
  cpuPkg::localAddrT base;
  base = cpuPkg::localAddrT'(op.address);
  if (op.mode == cpuPkg::modeIndirect) begin
    base = cpuPkg::localAddrT'(modelMem[base]);  // pointer word
  end
  return cpuPkg::localAddrT'((int'(base) + int'(op.delta)) % cpuPkg::LocalWords);
endfunction

function automatic cpuPkg::wordT operandValue(cpuPkg::operandT op);
  if (op.mode == cpuPkg::modeImmediate) begin
    return fieldValue(op);
  end
  return modelMem[slotOf(op)];
endfunction

// pushes that landed at or before a cycle
function automatic int visiblePushes(int cycle);
  int n = 0;
  for (int j = 0; j < pushCount; j++) begin
    if (pushEdge[j] <= cycle) begin
      n++;
    end
  end
  return n;
endfunction

task automatic predictOutputs();
  cpuPkg::instructionT instr;
  cpuPkg::wordT        a;
  cpuPkg::wordT        b;
  cpuPkg::wordT        value;
  cpuPkg::localAddrT   dest;
  int                  ip;
  int                  cycle;
  int                  seen;
  int                  taken;
  logic                store;
  logic                jump;
  expectedOut.delete();
  for (int i = 0; i < cpuPkg::LocalWords; i++) begin
    modelMem[i] = '0;  // start clears local memory
  end
  ip    = 0;
  cycle = 1;  // first execute cycle
  taken = 0;
  while (ip >= 0 && ip < codeLength) begin
    instr = code[ip];
    a     = operandValue(instr.source1);
    b     = operandValue(instr.source2);
    dest  = slotOf(instr.target);
    seen  = visiblePushes(cycle);
    value = '0;
    store = 1'b0;
    jump  = 1'b0;
    case (instr.opcode)
      cpuPkg::opAdd: begin
        value = a + b;
        store = 1'b1;
      end
      cpuPkg::opSubtract: begin
        value = a - b;
        store = 1'b1;
      end
      cpuPkg::opMov: begin
        value = a;
        store = 1'b1;
      end
      cpuPkg::opNot: begin
        value = (a == 0) ? cpuPkg::wordT'(1) : cpuPkg::wordT'(0);
        store = 1'b1;
      end
      cpuPkg::opJmp:    jump = 1'b1;
      cpuPkg::opJEq:    jump = (a == b);
      cpuPkg::opJLt:    jump = (a < b);
      cpuPkg::opJFalse: jump = (a == 0);
      cpuPkg::opIn: begin
        if (seen == taken) begin
          cycle = pushEdge[taken];  // stalls until the next word
        end
        value = pushWord[taken];
        taken++;
        store = 1'b1;
      end
      cpuPkg::opInSize: begin
        value = cpuPkg::wordT'(seen - taken);
        store = 1'b1;
      end
      cpuPkg::opOut: expectedOut.push_back(a);
      default: begin
      end
    endcase
    if (store && instr.target.mode != cpuPkg::modeImmediate) begin
      modelMem[dest] = value;
    end
    ip    = jump ? ip + int'(fieldValue(instr.target)) : ip + 1;
    cycle = cycle + 2;
  end
endtask

`endif

// File: sim/coreTb.sv
/*
  Random programs against an instruction-level model, several rounds.
  Each program has at most MaxIns in instructions and gets MaxIns late pushes,
  so every in is eventually served and the channel never fills.
*/
`timescale 1ns/1ps
`default_nettype none

module coreTb;

  localparam int Seed         = 45743;
  localparam int Rounds       = 6;
  localparam int MaxIns       = 3;
  localparam int MaxPushes    = 8;
  localparam int RoundTimeout = 400;  // cycles

  logic             clock;
  logic             arstN;
  logic             start;
  logic             inPush;
  logic             outValid;
  logic             finished;
  cpuPkg::codeLoadT codeLoad;
  cpuPkg::codeAddrT programLength;
  cpuPkg::wordT     inData;
  cpuPkg::wordT     outData;

  cpuPkg::instructionT code [cpuPkg::CodeWords];
  int                  codeLength;
  int                  pushEdge [MaxPushes];  // cycle after start
  cpuPkg::wordT        pushWord [MaxPushes];
  int                  pushCount;
  cpuPkg::wordT        modelMem [cpuPkg::LocalWords];
  cpuPkg::wordT        expectedOut [$];
  int                  outIndex;
  int                  valueErrors;
  int                  otherErrors;
  bit                  timedOut;

  `include "coreModel.svh"

  coreTop dut0 (
    .clock, .arstN, .codeLoad, .start, .programLength,
    .inPush, .inData, .outValid, .outData, .finished
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // --------------------
  // stimulus generation
  function automatic cpuPkg::operandT randomOperand();
    cpuPkg::operandT op;
    op.mode  = cpuPkg::modeT'($urandom_range(2, 0));
    op.delta = 4'($urandom_range(15, 0));
    if (op.mode == cpuPkg::modeImmediate) begin
      op.address = 10'($urandom_range(127, 0)) - 10'd64;  // small signed
    end else begin
      op.address = 10'($urandom_range(1023, 0));
    end
    return op;
  endfunction

  task automatic addPush(input int at);
    pushEdge[pushCount] = at;
    pushWord[pushCount] = cpuPkg::wordT'($urandom_range(4095, 0));
    pushCount++;
  endtask

  task automatic buildProgram();
    int pick;
    int ins;
    int at;
    int burst;
    ins        = 0;
    codeLength = $urandom_range(20, 12);
    for (int i = 0; i < codeLength; i++) begin
      pick = $urandom_range(15, 0);
      if (pick > 11 || (pick == 8 && ins == MaxIns)) begin
        pick = 10;  // extra weight on out
      end
      code[i].opcode  = cpuPkg::opcodeT'(pick);
      code[i].target  = randomOperand();
      code[i].source1 = randomOperand();
      code[i].source2 = randomOperand();
      if (code[i].opcode == cpuPkg::opIn) begin
        ins++;
      end
      if (code[i].opcode inside {cpuPkg::opJmp, cpuPkg::opJEq, cpuPkg::opJLt,
                                 cpuPkg::opJFalse}) begin
        code[i].target.mode    = cpuPkg::modeImmediate;
        code[i].target.delta   = '0;
        code[i].target.address = 10'($urandom_range(4, 1));  // forward only
      end
    end
    pushCount = 0;
    burst     = $urandom_range(4, 0);
    for (int j = 0; j < burst; j++) begin
      addPush(j);  // back to back from the start edge
    end
    at = burst + $urandom_range(40, 3);
    for (int j = 0; j < MaxIns; j++) begin
      addPush(at);
      at += $urandom_range(30, 5);
    end
  endtask

  // --------------------
  // checks
  task automatic checkOutput(input int round);
    cpuPkg::wordT expected;
    if (outValid) begin
      assert (expectedOut.size() > 0) else begin
        otherErrors++;
        $display("round %0d produced an output the model did not predict", round);
      end
      if (expectedOut.size() > 0) begin
        expected = expectedOut.pop_front();
        assert (outData == expected) else begin
          valueErrors++;
          $display("ERR round%0d.out%0d expected %0d actual %0d",
                   round, outIndex, expected, outData);
        end
        outIndex++;
      end
    end
  endtask

  task automatic checkQuietAfterReset();
    for (int i = 0; i < 10; i++) begin
      @(negedge clock);
      assert (!outValid && !finished) else begin
        valueErrors++;
        $display("ERR reset.quiet expected 00 actual %b%b", outValid, finished);
      end
    end
  endtask

  task automatic runRound(input int round);
    cpuPkg::codeLoadT load;
    int               cyc;
    int               nextPush;
    bit               seenFinish;
    for (int i = 0; i < codeLength; i++) begin
      load.valid       = 1'b1;
      load.address     = cpuPkg::codeAddrT'(i);
      load.instruction = code[i];
      @(posedge clock);
      codeLoad <= load;
    end
    @(posedge clock);
    codeLoad      <= '0;
    programLength <= cpuPkg::codeAddrT'(codeLength);
    cyc        = 0;
    nextPush   = 0;
    seenFinish = 1'b0;
    outIndex   = 0;
    while (!seenFinish || nextPush < pushCount) begin
      if (cyc == RoundTimeout) begin
        otherErrors++;
        timedOut = 1'b1;
        $display("round %0d did not finish within %0d cycles", round, RoundTimeout);
        return;
      end
      @(posedge clock);
      start  <= (cyc == 0);
      inPush <= 1'b0;
      if (nextPush < pushCount && pushEdge[nextPush] == cyc) begin
        inPush <= 1'b1;
        inData <= pushWord[nextPush];
        nextPush++;
      end
      @(negedge clock);
      checkOutput(round);
      if (cyc > 0 && finished && !seenFinish) begin  // old level until start lands
        seenFinish = 1'b1;
        assert (expectedOut.size() == 0) else begin
          otherErrors++;
          $display("round %0d finished with %0d outputs missing", round, expectedOut.size());
        end
      end
      cyc++;
    end
    @(posedge clock);
    start  <= 1'b0;
    inPush <= 1'b0;
  endtask

  // --------------------
  // main sequence
  initial begin
    arstN         = 1'b0;
    start         = 1'b0;
    inPush        = 1'b0;
    inData        = '0;
    codeLoad      = '0;
    programLength = '0;
    valueErrors   = 0;
    otherErrors   = 0;
    timedOut      = 1'b0;
    void'($urandom(Seed));
    repeat (5) @(posedge clock);
    arstN <= 1'b1;
    checkQuietAfterReset();
    for (int round = 0; round < Rounds && !timedOut; round++) begin
      buildProgram();
      predictOutputs();
      runRound(round);
    end
    $display("done: %0d value errors, %0d other errors", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+sim
logic/cpuPkg.sv
logic/codeMemory.sv
logic/instructionPointer.sv
logic/localStore.sv
logic/executeUnit.sv
logic/inChannel.sv
logic/sequencer.sv
logic/coreTop.sv
sim/coreTb.sv
